// File: asteroids_pocket_io.f
+incdir+hdl
hdl/asteroids_io_pkg.sv
hdl/pad_if.sv
hdl/pad_decoder.sv
hdl/button_merge.sv
hdl/dip_switch_regs.sv
hdl/video_formatter.sv
hdl/asteroids_io_top.sv
verification/asteroids_io_asserts.sv
verification/asteroids_io_tb.sv

// File: verification/asteroids_io_trace.txt
# kind a b c d e, all hex
# key: cont1 cont2 cab 0 0 / write: addr data lang ship bonus / video: hblank vblank hs vs {de,hs,vs}
key 00000008 00000000 7f 0 0
key 00000000 00000004 bf 0 0
key 00008000 00000000 df 0 0
key 00000000 00008000 ef 0 0
key 00000010 00000080 f3 0 0
key 00000040 00000020 fc 0 0
key 000080fc 00000000 10 0 0
key ffff7f03 00000010 f7 0 0
write 80000000 00000002 2 0 0
write 90000000 00000003 2 3 0
write 10000000 fffffffd 2 3 1
write 80000001 00000000 2 3 1
write 20000000 00000003 2 3 1
video 0 0 0 0 4
video 0 0 1 0 6
video 0 0 1 1 5
video 1 0 1 1 0
video 0 1 0 1 0
video 1 1 1 0 2
video 0 0 0 1 5
video 0 0 0 0 4

// File: verification/asteroids_io_tb.sv
// board glue testbench
// replays controller, bridge and video records from a trace file and
// checks each response, video colours from an lfsr

`timescale 1ns/1ps
`include "asteroids_io_defines.svh"

module asteroids_io_tb import asteroids_io_pkg::*; ();

  logic          clk_25_175;
  logic          arst_n;
  pad_key_t      cont1_key;
  pad_key_t      cont2_key;
  logic          bridge_wr;
  bridge_addr_t  bridge_addr;
  bridge_data_t  bridge_wr_data;
  color4_t       game_r;
  color4_t       game_g;
  color4_t       game_b;
  logic          game_hs;
  logic          game_vs;
  logic          game_hblank;
  logic          game_vblank;
  cab_buttons_t  cab_buttons;
  setting_t      language;
  setting_t      ship_count;
  setting_t      bonus;
  rgb888_t       video_rgb;
  logic          video_de;
  logic          video_hs;
  logic          video_vs;

  // trace records, one entry per field
  logic [63:0]   kind_q [$];
  logic [31:0]   a_q [$];
  logic [31:0]   b_q [$];
  logic [31:0]   c_q [$];
  logic [31:0]   d_q [$];
  logic [31:0]   e_q [$];
  int            num_records = 0;
  logic          records_ready = 1'b0;
  int            check_count = 0;
  int            error_count = 0;
  logic [31:0]   lfsr_state = 32'hddbb;

  asteroids_io_top UUT (.*);

  initial begin
    clk_25_175 = 1'b0;
    forever #4 clk_25_175 = ~clk_25_175;
  end

  //////////////////////
  // helpers
  //////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // galois step, x^32 + x^22 + x^2 + x + 1
  function automatic logic step_lfsr();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h80200003;
    end
    return out;
  endfunction

  function automatic color4_t random_nibble();
    color4_t n;
    n = '0;
    for (int i = 0; i < 4; i++) begin
      n = {n[2:0], step_lfsr()};
    end
    return n;
  endfunction

  // synchroniser stages plus the merge register
  task automatic press_keys(input int idx);
    @(posedge clk_25_175);
    cont1_key <= a_q[idx];
    cont2_key <= b_q[idx];
    repeat (`SYNC_STAGES + 1) @(posedge clk_25_175);
    @(negedge clk_25_175);
    check_value($sformatf("key %0d cab_buttons", idx), c_q[idx], cab_buttons);
  endtask

  task automatic bridge_write(input int idx);
    @(posedge clk_25_175);
    bridge_wr      <= 1'b1;
    bridge_addr    <= a_q[idx];
    bridge_wr_data <= b_q[idx];
    @(posedge clk_25_175);
    bridge_wr      <= 1'b0;
    @(negedge clk_25_175);
    check_value($sformatf("write %0d language", idx), c_q[idx], language);
    check_value($sformatf("write %0d ship_count", idx), d_q[idx], ship_count);
    check_value($sformatf("write %0d bonus", idx), e_q[idx], bonus);
  endtask

  task automatic video_cycle(input int idx);
    color4_t     r_val;
    color4_t     g_val;
    color4_t     b_val;
    logic [23:0] exp_rgb;
    r_val = random_nibble();
    g_val = random_nibble();
    b_val = random_nibble();
    @(posedge clk_25_175);
    game_r      <= r_val;
    game_g      <= g_val;
    game_b      <= b_val;
    game_hblank <= a_q[idx][0];
    game_vblank <= b_q[idx][0];
    game_hs     <= c_q[idx][0];
    game_vs     <= d_q[idx][0];
    @(posedge clk_25_175);
    @(negedge clk_25_175);
    // x * 17 widens a nibble to a full-scale byte
    exp_rgb = '0;
    if (!(a_q[idx][0] || b_q[idx][0])) begin
      exp_rgb = {r_val * 8'd17, g_val * 8'd17, b_val * 8'd17};
    end
    check_value($sformatf("video %0d de", idx), e_q[idx][2], video_de);
    check_value($sformatf("video %0d hs", idx), e_q[idx][1], video_hs);
    check_value($sformatf("video %0d vs", idx), e_q[idx][0], video_vs);
    check_value($sformatf("video %0d rgb", idx), exp_rgb, video_rgb);
  endtask

  //////////////////////
  // main sequence
  //////////////////////

  initial begin
    int               fd;
    int               n;
    logic [8*128-1:0] line;
    logic [63:0]      kind;
    logic [31:0]      f0;
    logic [31:0]      f1;
    logic [31:0]      f2;
    logic [31:0]      f3;
    logic [31:0]      f4;
    arst_n         = 1'b0;
    cont1_key      = '0;
    cont2_key      = '0;
    bridge_wr      = 1'b0;
    bridge_addr    = '0;
    bridge_wr_data = '0;
    game_r         = '0;
    game_g         = '0;
    game_b         = '0;
    game_hs        = 1'b0;
    game_vs        = 1'b0;
    // blanked until the video records start
    game_hblank    = 1'b1;
    game_vblank    = 1'b1;
    fd = $fopen("verification/asteroids_io_trace.txt", "r");
    if (fd == 0) begin
      error_count++;
      $display("could not open the trace file");
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        kind = '0;
        if ($fgets(line, fd) != 0) begin
          n = $sscanf(line, "%s %h %h %h %h %h", kind, f0, f1, f2, f3, f4);
          // comment lines start with a lone #
          if (n == 6 && kind != "#") begin
            kind_q.push_back(kind);
            a_q.push_back(f0);
            b_q.push_back(f1);
            c_q.push_back(f2);
            d_q.push_back(f3);
            e_q.push_back(f4);
          end else if (n > 0 && kind != "#") begin
            error_count++;
            $display("trace line with a wrong number of fields");
          end
        end
      end
      $fclose(fd);
    end
    num_records   = kind_q.size();
    records_ready = 1'b1;

    repeat (10) @(posedge clk_25_175);
    arst_n <= 1'b1;
    @(negedge clk_25_175);
    check_value("reset cab_buttons", 32'hff, cab_buttons);
    check_value("reset language", 32'h0, language);
    check_value("reset ship_count", 32'h0, ship_count);
    check_value("reset bonus", 32'h0, bonus);
    check_value("reset video", 32'h0, {video_rgb, video_de, video_hs, video_vs});

    foreach (kind_q[i]) begin
      case (kind_q[i])
        "key":   press_keys(i);
        "write": bridge_write(i);
        "video": video_cycle(i);
        default: begin
          error_count++;
          $display("trace record %0d has an unknown kind", i);
        end
      endcase
    end

    // failed properties of the bound checker
    error_count += UUT.u_asserts.failure_count;

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog, sized from the record count with reset time as margin
  initial begin
    wait (records_ready);
    repeat ((num_records + 1) * 20 + 10) @(posedge clk_25_175);
    $display("timeout, the trace did not complete in the allowed cycles");
    $display("Something failed");
    $finish;
  end

endmodule

// File: verification/asteroids_io_asserts.sv
// board glue assertions
// sync pulse width, blanked colour and reset values at the top level

`timescale 1ns/1ps

module asteroids_io_asserts import asteroids_io_pkg::*; (
  input logic          clk_25_175,
  input logic          arst_n,
  input cab_buttons_t  cab_buttons,
  input setting_t      language,
  input setting_t      ship_count,
  input setting_t      bonus,
  input rgb888_t       video_rgb,
  input logic          video_de,
  input logic          video_hs,
  input logic          video_vs
);

  // failed properties so far
  int failure_count = 0;

  // sync outputs are single-cycle pulses
  assert property (@(posedge clk_25_175) disable iff (!arst_n) video_hs |=> !video_hs)
    else begin
      $error("video_hs high for two cycles in a row");
      failure_count++;
    end
  assert property (@(posedge clk_25_175) disable iff (!arst_n) video_vs |=> !video_vs)
    else begin
      $error("video_vs high for two cycles in a row");
      failure_count++;
    end

  // black outside the visible area
  assert property (@(posedge clk_25_175) disable iff (!arst_n) !video_de |-> video_rgb == '0)
    else begin
      $error("video_rgb not zero while video_de is low");
      failure_count++;
    end

  // sampled mid-cycle, after the first edge has cleared everything
  assert property (@(negedge clk_25_175) !arst_n |->
                   (cab_buttons == '1) && (language == '0) && (ship_count == '0) &&
                   (bonus == '0) && (video_rgb == '0) && !video_de && !video_hs && !video_vs)
    else begin
      $error("outputs left their reset values while arst_n was low");
      failure_count++;
    end

endmodule

bind asteroids_io_top asteroids_io_asserts u_asserts (.*);

// File: hdl/asteroids_io_top.sv
// asteroids board glue top
// controller mapping, bridge settings registers and video
// formatting around the game core, one clock domain

`timescale 1ns/1ps
`include "asteroids_io_defines.svh"

module asteroids_io_top import asteroids_io_pkg::*; (
  input  logic          clk_25_175,
  input  logic          arst_n,
  // host controllers
  input  pad_key_t      cont1_key,
  input  pad_key_t      cont2_key,
  // bridge writes
  input  logic          bridge_wr,
  input  bridge_addr_t  bridge_addr,
  input  bridge_data_t  bridge_wr_data,
  // game video
  input  color4_t       game_r,
  input  color4_t       game_g,
  input  color4_t       game_b,
  input  logic          game_hs,
  input  logic          game_vs,
  input  logic          game_hblank,
  input  logic          game_vblank,
  // to the game core
  output cab_buttons_t  cab_buttons,
  output setting_t      language,
  output setting_t      ship_count,
  output setting_t      bonus,
  // to the scaler
  output rgb888_t       video_rgb,
  output logic          video_de,
  output logic          video_hs,
  output logic          video_vs
);

  //////////////////////
  // controllers
  //////////////////////

  // key words indexed by pad
  pad_key_t pad_keys [0:`NUM_PADS-1];

  assign pad_keys[0] = cont1_key;
  assign pad_keys[1] = cont2_key;

  // one decoded button set per player
  pad_if pad_bus [0:`NUM_PADS-1] ();

  for (genvar i = 0; i < `NUM_PADS; i++) begin : g_pad
    pad_decoder u_pad_decoder (
      .clk_25_175 (clk_25_175),
      .arst_n     (arst_n),
      .key        (pad_keys[i]),
      .pad        (pad_bus[i])
    );
  end

  button_merge u_button_merge (
    .clk_25_175  (clk_25_175),
    .arst_n      (arst_n),
    .pads        (pad_bus),
    .cab_buttons (cab_buttons)
  );

  //////////////////////
  // settings and video
  //////////////////////

  dip_switch_regs u_dip_switch_regs (
    .clk_25_175     (clk_25_175),
    .arst_n         (arst_n),
    .bridge_wr      (bridge_wr),
    .bridge_addr    (bridge_addr),
    .bridge_wr_data (bridge_wr_data),
    .language       (language),
    .ship_count     (ship_count),
    .bonus          (bonus)
  );

  video_formatter u_video_formatter (
    .clk_25_175 (clk_25_175),
    .arst_n     (arst_n),
    .r          (game_r),
    .g          (game_g),
    .b          (game_b),
    .hs         (game_hs),
    .vs         (game_vs),
    .hblank     (game_hblank),
    .vblank     (game_vblank),
    .video_rgb  (video_rgb),
    .video_de   (video_de),
    .video_hs   (video_hs),
    .video_vs   (video_vs)
  );

endmodule

// File: hdl/video_formatter.sv
// video formatter
// widens the game's 4-bit colour to 24-bit rgb, builds the
// data-enable from blanking and turns sync edges into pulses

`timescale 1ns/1ps

module video_formatter import asteroids_io_pkg::*; (
  input  logic     clk_25_175,
  input  logic     arst_n,
  input  color4_t  r,
  input  color4_t  g,
  input  color4_t  b,
  input  logic     hs,
  input  logic     vs,
  input  logic     hblank,
  input  logic     vblank,
  output rgb888_t  video_rgb,
  output logic     video_de,
  output logic     video_hs,
  output logic     video_vs
);

  // nibble repeated so full scale stays full scale
  rgb888_t rgb_expanded;
  // visible area
  logic    active;
  // previous sync samples
  logic    hs_prev;
  logic    vs_prev;

  assign rgb_expanded = {{2{r}}, {2{g}}, {2{b}}};
  assign active       = ~(hblank | vblank);

  //////////////////////
  // output register
  //////////////////////

  always_ff @(posedge clk_25_175 or negedge arst_n) begin
    if (!arst_n) begin
      video_rgb <= '0;
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
    end else begin
      video_de  <= active;
      // colour forced black while blanked
      video_rgb <= active ? rgb_expanded : '0;
      // single-cycle pulse on a low to high step
      video_hs  <= hs & ~hs_prev;
      video_vs  <= vs & ~vs_prev;
      hs_prev   <= hs;
      vs_prev   <= vs;
    end
  end

endmodule

// File: hdl/dip_switch_regs.sv
// cabinet dip switch registers
// host writes language, ship count and bonus over the bridge,
// each at its own exact address

`timescale 1ns/1ps
`include "asteroids_io_defines.svh"

module dip_switch_regs import asteroids_io_pkg::*; (
  input  logic          clk_25_175,
  input  logic          arst_n,
  input  logic          bridge_wr,
  input  bridge_addr_t  bridge_addr,
  input  bridge_data_t  bridge_wr_data,
  output setting_t      language,
  output setting_t      ship_count,
  output setting_t      bonus
);

  // low bits of the data word carry the setting
  setting_t wr_value;

  assign wr_value = bridge_wr_data[$bits(setting_t)-1:0];

  //////////////////////
  // address decode
  //////////////////////

  always_ff @(posedge clk_25_175 or negedge arst_n) begin
    if (!arst_n) begin
      language   <= '0;
      ship_count <= '0;
      bonus      <= '0;
    end else if (bridge_wr) begin
      // full 32-bit compare, anything else falls through
      case (bridge_addr)
        `ADDR_LANGUAGE: begin
          language <= wr_value;
        end
        `ADDR_SHIP_COUNT: begin
          ship_count <= wr_value;
        end
        `ADDR_BONUS: begin
          bonus <= wr_value;
        end
        default: begin
          // not ours, registers hold
        end
      endcase
    end
  end

endmodule

// File: hdl/button_merge.sv
// button merge
// folds both players onto the cabinet button byte, shared
// functions ORed, starts kept per player, registered active low

`timescale 1ns/1ps
`include "asteroids_io_defines.svh"

module button_merge import asteroids_io_pkg::*; (
  input  logic          clk_25_175,
  input  logic          arst_n,
  pad_if.merge          pads [0:`NUM_PADS-1],
  output cab_buttons_t  cab_buttons
);

  // per-pad levels gathered into vectors
  logic [`NUM_PADS-1:0] right_v, left_v, start_v, fire_v;
  logic [`NUM_PADS-1:0] aux_v, thrust_v, hyper_v;
  cab_buttons_t         buttons_next;

  for (genvar i = 0; i < `NUM_PADS; i++) begin : g_gather
    assign right_v[i]  = pads[i].right;
    assign left_v[i]   = pads[i].left;
    assign start_v[i]  = pads[i].start;
    assign fire_v[i]   = pads[i].fire;
    assign aux_v[i]    = pads[i].aux;
    assign thrust_v[i] = pads[i].thrust;
    assign hyper_v[i]  = pads[i].hyper;
  end

  // cabinet layout, bit 7 down to bit 0
  // p1 start from pad 0, p2 start from pad 1
  assign buttons_next = ~{|right_v, |left_v, start_v[0], start_v[1],
                          |fire_v, |aux_v, |thrust_v, |hyper_v};

  // all released out of reset
  always_ff @(posedge clk_25_175 or negedge arst_n) begin
    if (!arst_n) begin
      cab_buttons <= '1;
    end else begin
      cab_buttons <= buttons_next;
    end
  end

endmodule

// File: hdl/pad_decoder.sv
// pad decoder
// brings one host key word into clk_25_175 and picks out the
// bits used by the cabinet, all active high

`timescale 1ns/1ps
`include "asteroids_io_defines.svh"

module pad_decoder import asteroids_io_pkg::*; (
  input  logic          clk_25_175,
  input  logic          arst_n,
  input  pad_key_t      key,
  pad_if.decoder        pad
);

  // synchroniser chain, stage 0 samples the host word
  pad_key_t sync_q [`SYNC_STAGES];
  pad_key_t key_s;

  always_ff @(posedge clk_25_175 or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= key;
      for (int i = 1; i < `SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // last stage feeds the decode
  assign key_s = sync_q[`SYNC_STAGES-1];

  //////////////////////
  // key bits to buttons
  //////////////////////

  assign pad.right  = key_s[`KEY_RIGHT];
  assign pad.left   = key_s[`KEY_LEFT];
  assign pad.start  = key_s[`KEY_START];
  assign pad.fire   = key_s[`KEY_FACE_A];
  assign pad.hyper  = key_s[`KEY_FACE_B];
  assign pad.thrust = key_s[`KEY_FACE_X];
  assign pad.aux    = key_s[`KEY_FACE_Y];

endmodule

// File: hdl/pad_if.sv
// decoded buttons of one player
// active-high levels, driven by the pad decoder, read by the merge

`timescale 1ns/1ps

interface pad_if;

  // cabinet functions
  logic right;
  logic left;
  logic start;
  logic fire;
  logic thrust;
  logic hyper;
  // face y, lands on cabinet bit 2
  logic aux;

  // producer side
  modport decoder (output right, left, start, fire, thrust, hyper, aux);

  // consumer side
  modport merge (input right, left, start, fire, thrust, hyper, aux);

endinterface

// File: hdl/asteroids_io_pkg.sv
// asteroids board glue types
// vector typedefs for the widths that carry a meaning on the
// game, controller and bridge sides

`include "asteroids_io_defines.svh"

package asteroids_io_pkg;

  // raw game colour channel, one nibble
  typedef logic [`COLOR_W-1:0] color4_t;

  // formatted pixel, r in the top byte
  typedef logic [6*`COLOR_W-1:0] rgb888_t;

  // host controller key bitmap
  typedef logic [`KEY_W-1:0] pad_key_t;

  // cabinet buttons, 0 = pressed
  typedef logic [`CAB_W-1:0] cab_buttons_t;

  // one settings value
  typedef logic [`SETTING_W-1:0] setting_t;

  // bridge bus words
  typedef logic [`BRIDGE_W-1:0] bridge_addr_t;
  typedef logic [`BRIDGE_W-1:0] bridge_data_t;

endpackage

// File: hdl/asteroids_io_defines.svh
// asteroids board glue constants
// bridge map of the settings registers, controller key bit positions,
// pad count and the widths behind the package types

`ifndef ASTEROIDS_IO_DEFINES_SVH
`define ASTEROIDS_IO_DEFINES_SVH

// bridge addresses, matched exactly on a write
`define ADDR_LANGUAGE   32'h80000000
`define ADDR_SHIP_COUNT 32'h90000000
`define ADDR_BONUS      32'h10000000

// host controller key bitmap positions
`define KEY_LEFT   2
`define KEY_RIGHT  3
`define KEY_FACE_A 4
`define KEY_FACE_B 5
`define KEY_FACE_X 6
`define KEY_FACE_Y 7
`define KEY_START  15

// controllers and synchroniser depth
`define NUM_PADS    2
`define SYNC_STAGES 2

// field widths
`define COLOR_W   4
`define KEY_W     32
`define CAB_W     8
`define SETTING_W 2
`define BRIDGE_W  32

`endif
